// ==== logic/cmd_line_pkg.sv ====
/* Command line protocol definitions
   Encoder states, line byte type and fixed line patterns */
package cmd_line_pkg;

    // One byte as it is shifted onto the command line
    typedef logic [7:0] cmd_byte_t;

    // Encoder line modes
    typedef enum logic [1:0] {
        ENC_INIT  = 2'd0,                   // Toggle pattern for receiver PLL lock
        ENC_SYNC  = 2'd1,                   // Idle sync stream
        ENC_WRITE = 2'd2                    // Command memory playback
    } enc_state_e;

    // Symmetric idle pattern, alternating bits on the line
    localparam cmd_byte_t SYNC_BYTE = 8'hAA;

    // Line level right after reset, toggled every clock in ENC_INIT
    localparam logic INIT_LINE_LEVEL = 1'b0;

    // Serializer bit timer value on the last bit of a byte
    localparam logic [2:0] BIT_LAST = 3'd7;

    // Stages between the enable request and cmd_en
    localparam int EN_DELAY_STAGES = 3;

endpackage

// ==== logic/cmd_cfg_pkg.sv ====
/* Command encoder configuration definitions
   Memory write strobe and playback configuration */
package cmd_cfg_pkg;

    // Address field of the write strobe, largest supported memory
    localparam int MEM_ADDR_W = 12;

    // Width of the size and repeat fields
    localparam int CFG_W = 16;

    // Command memory write strobe, one byte per cycle with en high
    typedef struct packed {
        logic                    en;
        logic [MEM_ADDR_W-1:0]   addr;
        cmd_line_pkg::cmd_byte_t data;
    } mem_wr_t;

    // Playback configuration, held while a playback runs
    typedef struct packed {
        logic [CFG_W-1:0] cmd_size;         // Bytes per pass
        logic [CFG_W-1:0] repeat_count;     // Passes per start
    } play_cfg_t;

endpackage

// ==== logic/cmd_sequencer_fsm.sv ====
`timescale 1ns/100ps

/* Command encoder sequencer
   Selects lock pattern, sync idle or playback and delays the line enable */
module cmd_sequencer_fsm (
    input  logic                     CMD_CLK,
    input  logic                     RST_SYNC,
    input  logic                     start,
    input  cmd_cfg_pkg::play_cfg_t   cfg,
    input  logic                     byte_tick,
    input  logic                     pair_tick,
    input  logic                     last_byte,
    output cmd_line_pkg::enc_state_e state,
    output logic                     ser_run,
    output logic                     cmd_en,
    output logic                     play_step,
    output logic                     cmd_writing,
    output logic                     done
);

    localparam int EN_N = cmd_line_pkg::EN_DELAY_STAGES;

    cmd_line_pkg::enc_state_e state_nxt;
    logic                     pending;
    logic                     req;
    logic                     go_write;
    logic                     play_end;
    logic [EN_N-1:0]          en_dly;

    assign req         = start && (cfg.cmd_size != 16'd0);  // Empty commands are dropped
    assign play_step   = (state == cmd_line_pkg::ENC_WRITE) && byte_tick;
    assign play_end    = play_step && last_byte;
    assign go_write    = (state == cmd_line_pkg::ENC_SYNC) && pending && pair_tick;
    assign cmd_writing = (state == cmd_line_pkg::ENC_WRITE);
    assign ser_run     = en_dly[0];
    assign cmd_en      = en_dly[EN_N-1];

    always_comb begin
        state_nxt = state;
        case (state)
            cmd_line_pkg::ENC_INIT: begin
                if (start)
                    state_nxt = cmd_line_pkg::ENC_SYNC;
            end
            cmd_line_pkg::ENC_SYNC: begin
                if (go_write)               // Switch only on a byte pair boundary
                    state_nxt = cmd_line_pkg::ENC_WRITE;
            end
            cmd_line_pkg::ENC_WRITE: begin
                if (play_end)
                    state_nxt = cmd_line_pkg::ENC_SYNC;
            end
            default: state_nxt = cmd_line_pkg::ENC_INIT;
        endcase
    end

    always_ff @(posedge CMD_CLK) begin
        if (RST_SYNC) begin
            state   <= cmd_line_pkg::ENC_INIT;
            pending <= 1'b0;
            en_dly  <= '0;
            done    <= 1'b0;
        end else begin
            state  <= state_nxt;
            en_dly <= {en_dly[EN_N-2:0], state != cmd_line_pkg::ENC_INIT};
            done   <= play_end;
            // A start during playback queues one more run
            if (req && state != cmd_line_pkg::ENC_INIT)
                pending <= 1'b1;
            else if (go_write)
                pending <= 1'b0;
        end
    end

    // done only on the cycle after leaving playback
    a_done_on_return: assert property (@(posedge CMD_CLK) disable iff (RST_SYNC)
        done |-> state == cmd_line_pkg::ENC_SYNC && $past(state) == cmd_line_pkg::ENC_WRITE);

    // Steps only while writing and the serializer runs
    a_step_in_write: assert property (@(posedge CMD_CLK) disable iff (RST_SYNC)
        play_step |-> state == cmd_line_pkg::ENC_WRITE && ser_run);

endmodule

// ==== logic/cmd_loop_counter.sv ====
`timescale 1ns/100ps

/* Playback address and repeat counters
   Walks the command block and flags the final byte and each pass start */
module cmd_loop_counter #(
    parameter int MEM_AW = 12
) (
    input  logic                   CMD_CLK,
    input  logic                   RST_SYNC,
    input  cmd_cfg_pkg::play_cfg_t cfg,
    input  logic                   play_step,
    output logic [MEM_AW-1:0]      rd_addr,
    output logic                   last_byte,
    output logic                   loop_start
);

    logic [15:0] rep_cnt;
    logic        addr_last;
    logic        rep_last;

    assign addr_last = (16'(rd_addr) == cfg.cmd_size - 16'd1);
    // Zero repeats behave like a single pass
    assign rep_last  = ({1'b0, rep_cnt} + 17'd1) >= {1'b0, cfg.repeat_count};
    assign last_byte = addr_last && rep_last;

    always_ff @(posedge CMD_CLK) begin
        if (RST_SYNC) begin
            rd_addr    <= '0;
            rep_cnt    <= '0;
            loop_start <= 1'b0;
        end else if (play_step) begin
            // Byte leaving now opens a pass
            loop_start <= (rd_addr == '0) && (cfg.repeat_count != 16'd1);
            if (last_byte) begin
                rd_addr <= '0;              // Ready for the next start
                rep_cnt <= '0;
            end else if (addr_last) begin
                rd_addr <= '0;
                rep_cnt <= rep_cnt + 16'd1;
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // Read address stays inside the configured block
    a_addr_in_block: assert property (@(posedge CMD_CLK) disable iff (RST_SYNC)
        play_step |-> 16'(rd_addr) < cfg.cmd_size);

endmodule

// ==== logic/cmd_memory.sv ====
`timescale 1ns/100ps

/* Command byte memory
   Single write port, registered read port for playback */
module cmd_memory #(
    parameter int MEM_AW = 12
) (
    input  logic                    CMD_CLK,
    input  cmd_cfg_pkg::mem_wr_t    mem_wr,
    input  logic [MEM_AW-1:0]       rd_addr,
    output cmd_line_pkg::cmd_byte_t rd_data
);

    localparam int DEPTH = 1 << MEM_AW;

    cmd_line_pkg::cmd_byte_t mem [DEPTH];

    always_ff @(posedge CMD_CLK) begin
        if (mem_wr.en)
            mem[mem_wr.addr[MEM_AW-1:0]] <= mem_wr.data;  // Upper address bits unused
    end

    always_ff @(posedge CMD_CLK) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== logic/cmd_serializer.sv ====
`timescale 1ns/100ps

/* Command line serializer
   Picks sync or memory bytes and shifts them out MSB first */
module cmd_serializer #(
    parameter int MEM_AW = 12
) (
    input  logic                     CMD_CLK,
    input  logic                     RST_SYNC,
    input  logic                     ser_run,
    input  cmd_line_pkg::enc_state_e state,
    input  cmd_line_pkg::cmd_byte_t  rd_data,
    output logic                     byte_tick,
    output logic                     pair_tick,
    output logic                     serial_out
);

    logic [2:0]              bit_cnt;
    logic                    byte_par;
    cmd_line_pkg::cmd_byte_t src_q;
    cmd_line_pkg::cmd_byte_t shift_q;

    // Memory depth is bounded by the write strobe address field
    if (MEM_AW < 1 || MEM_AW > cmd_cfg_pkg::MEM_ADDR_W) begin : g_aw_check
        $fatal(1, "MEM_AW %0d exceeds the command memory address field", MEM_AW);
    end

    assign byte_tick = ser_run && (bit_cnt == cmd_line_pkg::BIT_LAST);
    assign pair_tick = byte_tick && !byte_par;     // Even byte boundary

    always_ff @(posedge CMD_CLK) begin
        if (RST_SYNC) begin
            bit_cnt  <= '0;
            byte_par <= 1'b0;
        end else if (ser_run) begin
            bit_cnt <= bit_cnt + 3'd1;             // Wraps after the last bit
            if (byte_tick)
                byte_par <= ~byte_par;
        end else begin
            bit_cnt <= '0;
        end
    end

    // Next byte for the line, taken at the coming byte_tick
    always_ff @(posedge CMD_CLK) begin
        if (state == cmd_line_pkg::ENC_WRITE)
            src_q <= rd_data;
        else
            src_q <= cmd_line_pkg::SYNC_BYTE;
    end

    always_ff @(posedge CMD_CLK) begin
        if (RST_SYNC) begin
            shift_q    <= cmd_line_pkg::SYNC_BYTE;  // Sync bits from the first shift
            serial_out <= cmd_line_pkg::INIT_LINE_LEVEL;
        end else begin
            if (state == cmd_line_pkg::ENC_INIT)
                serial_out <= ~serial_out;        // 0101 lock pattern
            else if (ser_run)
                serial_out <= shift_q[7];
            if (ser_run) begin
                if (byte_tick)
                    shift_q <= src_q;
                else
                    shift_q <= {shift_q[6:0], 1'b0};
            end
        end
    end

    // One byte boundary per 8 bits, no gaps between bytes
    a_byte_period: assert property (@(posedge CMD_CLK) disable iff (RST_SYNC || !ser_run)
        byte_tick |=> !byte_tick [*7] ##1 byte_tick);

endmodule

// ==== logic/cmd_encoder_top.sv ====
`timescale 1ns/100ps

/* Command stream encoder top level
   Sequencer, playback counters, command memory and line serializer */
module cmd_encoder_top #(
    parameter int MEM_AW = 12
) (
    input  logic                   CMD_CLK,
    input  logic                   RST_SYNC,
    input  logic                   start,
    input  cmd_cfg_pkg::mem_wr_t   mem_wr,
    input  cmd_cfg_pkg::play_cfg_t cfg,
    output logic                   serial_out,
    output logic                   cmd_en,
    output logic                   cmd_writing,
    output logic                   loop_start,
    output logic                   done
);

    cmd_line_pkg::enc_state_e state;
    cmd_line_pkg::cmd_byte_t  rd_data;
    logic [MEM_AW-1:0]        rd_addr;
    logic                     ser_run;
    logic                     play_step;
    logic                     byte_tick;
    logic                     pair_tick;
    logic                     last_byte;

    cmd_sequencer_fsm u_fsm (
        .CMD_CLK     (CMD_CLK),
        .RST_SYNC    (RST_SYNC),
        .start       (start),
        .cfg         (cfg),
        .byte_tick   (byte_tick),
        .pair_tick   (pair_tick),
        .last_byte   (last_byte),
        .state       (state),
        .ser_run     (ser_run),
        .cmd_en      (cmd_en),
        .play_step   (play_step),
        .cmd_writing (cmd_writing),
        .done        (done)
    );

    cmd_loop_counter #(
        .MEM_AW (MEM_AW)
    ) u_counter (
        .CMD_CLK    (CMD_CLK),
        .RST_SYNC   (RST_SYNC),
        .cfg        (cfg),
        .play_step  (play_step),
        .rd_addr    (rd_addr),
        .last_byte  (last_byte),
        .loop_start (loop_start)
    );

    cmd_memory #(
        .MEM_AW (MEM_AW)
    ) u_memory (
        .CMD_CLK (CMD_CLK),
        .mem_wr  (mem_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    cmd_serializer #(
        .MEM_AW (MEM_AW)
    ) u_serializer (
        .CMD_CLK    (CMD_CLK),
        .RST_SYNC   (RST_SYNC),
        .ser_run    (ser_run),
        .state      (state),
        .rd_data    (rd_data),
        .byte_tick  (byte_tick),
        .pair_tick  (pair_tick),
        .serial_out (serial_out)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/100ps

/* Testbench clock and reset source
   Free running CMD_CLK with a synchronous reset held after power up */
module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic CMD_CLK,
    output logic RST_SYNC
);

    initial begin
        CMD_CLK = 1'b0;
        forever #(PERIOD_NS / 2) CMD_CLK = ~CMD_CLK;
    end

    initial begin
        RST_SYNC = 1'b1;
        repeat (RESET_CYCLES) @(posedge CMD_CLK);
        RST_SYNC <= 1'b0;                   // Released on a clock edge
    end

endmodule

// ==== verification/cmd_encoder_tb.sv ====
`timescale 1ns/100ps

/* Command encoder testbench
   Plays table driven command blocks and checks the serial line stream */
module cmd_encoder_tb;

    localparam int MEM_AW     = 12;
    localparam int NUM_TESTS  = 6;
    localparam int CLK_PERIOD = 10;
    localparam int TAIL_BITS  = 24;          // Last byte latency plus sync after done
    localparam int MAX_OFFSET = 16;
    localparam logic [31:0] LFSR_SEED = 32'h5fe3;

    typedef struct packed {
        logic [15:0] cmd_size;
        logic [15:0] repeat_count;
        logic        reseed;                 // Restart the byte LFSR
    } test_entry_t;

    // A one-byte block keeps loop_start high, so it only runs a single pass
    localparam test_entry_t TESTS [NUM_TESTS] = '{
        '{16'd4,  16'd1, 1'b1},
        '{16'd3,  16'd3, 1'b0},
        '{16'd1,  16'd1, 1'b0},
        '{16'd0,  16'd2, 1'b0},
        '{16'd16, 16'd2, 1'b0},
        '{16'd5,  16'd4, 1'b1}
    };

    logic                   CMD_CLK;
    logic                   RST_SYNC;
    logic                   start;
    cmd_cfg_pkg::mem_wr_t   mem_wr;
    cmd_cfg_pkg::play_cfg_t cfg;
    logic                   serial_out;
    logic                   cmd_en;
    logic                   cmd_writing;
    logic                   loop_start;
    logic                   done;

    logic [31:0]             lfsr;
    cmd_line_pkg::cmd_byte_t block [$];

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (16)
    ) u_clk (
        .CMD_CLK  (CMD_CLK),
        .RST_SYNC (RST_SYNC)
    );

    cmd_encoder_top #(
        .MEM_AW (MEM_AW)
    ) dut (
        .CMD_CLK     (CMD_CLK),
        .RST_SYNC    (RST_SYNC),
        .start       (start),
        .mem_wr      (mem_wr),
        .cfg         (cfg),
        .serial_out  (serial_out),
        .cmd_en      (cmd_en),
        .cmd_writing (cmd_writing),
        .loop_start  (loop_start),
        .done        (done)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic longint watchdog_cycles();
        longint total;
        int     i;
        total = 500;
        for (i = 0; i < NUM_TESTS; i++)
            total += 8 * longint'(TESTS[i].cmd_size) * longint'(TESTS[i].repeat_count) + 200;
        return total;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_failure($sformatf("ERROR time %0t: %s expected %0h actual %0h",
                                    $time, sig, expected, actual));
    endtask

    task automatic make_byte(output cmd_line_pkg::cmd_byte_t b);
        int n;
        b = '0;
        for (n = 0; n < 8; n++) begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
        if (b == 8'hAA)
            b = 8'h3C;                       // Keep data distinct from sync
    endtask

    task automatic drive_start();
        @(posedge CMD_CLK);
        start <= 1'b1;
        @(posedge CMD_CLK);
        start <= 1'b0;
    endtask

    task automatic load_block(input test_entry_t t);
        cmd_line_pkg::cmd_byte_t b;
        int                      k;
        if (t.reseed)
            lfsr = LFSR_SEED;
        block.delete();
        for (k = 0; k < int'(t.cmd_size); k++) begin
            make_byte(b);
            block.push_back(b);
            @(posedge CMD_CLK);
            mem_wr <= '{en: 1'b1, addr: 12'(k), data: b};
        end
        @(posedge CMD_CLK);
        mem_wr <= '0;
        cfg    <= '{cmd_size: t.cmd_size, repeat_count: t.repeat_count};
    endtask

    task automatic check_lock_pattern(input int cycles);
        logic prev;
        @(negedge CMD_CLK);
        prev = serial_out;
        repeat (cycles) begin
            @(negedge CMD_CLK);
            assert (cmd_en == 1'b0) else report_mismatch("cmd_en", 0, cmd_en);
            assert (cmd_writing == 1'b0) else report_mismatch("cmd_writing", 0, cmd_writing);
            assert (serial_out == !prev) else report_mismatch("serial_out", !prev, serial_out);
            prev = serial_out;
        end
    endtask

    // Sync idle, no playback activity
    task automatic check_idle_line(input int cycles);
        logic prev;
        @(negedge CMD_CLK);
        prev = serial_out;
        repeat (cycles) begin
            @(negedge CMD_CLK);
            assert (cmd_en == 1'b1) else report_mismatch("cmd_en", 1, cmd_en);
            assert (cmd_writing == 1'b0) else report_mismatch("cmd_writing", 0, cmd_writing);
            assert (done == 1'b0) else report_mismatch("done", 0, done);
            assert (serial_out == !prev) else report_mismatch("serial_out", !prev, serial_out);
            prev = serial_out;
        end
    endtask

    task automatic run_playback(input test_entry_t t);
        logic exp_bits [$];
        logic cap_bits [$];
        int   size;
        int   reps;
        int   r;
        int   k;
        int   b;
        int   i;
        int   waited;
        int   tail;
        int   rises;
        int   dones;
        int   found_at;
        logic prev_loop;
        logic match;
        size = int'(t.cmd_size);
        reps = int'(t.repeat_count);
        load_block(t);
        for (r = 0; r < reps; r++)
            for (k = 0; k < size; k++)
                for (b = 7; b >= 0; b--)
                    exp_bits.push_back(block[k][b]);   // MSB first
        drive_start();
        waited = 0;
        do begin
            @(negedge CMD_CLK);
            waited++;
        end while (!cmd_writing && waited < 64);
        assert (cmd_writing) else stop_with_failure("cmd_writing did not rise after start");
        tail      = -1;
        rises     = 0;
        dones     = 0;
        prev_loop = loop_start;
        while (tail != 0) begin
            cap_bits.push_back(serial_out);
            assert (cmd_en == 1'b1) else report_mismatch("cmd_en", 1, cmd_en);
            if (cmd_writing && loop_start && !prev_loop)
                rises++;
            prev_loop = loop_start;
            if (done) begin
                dones++;
                assert (cmd_writing == 1'b0) else report_mismatch("cmd_writing", 0, cmd_writing);
            end
            if (tail > 0)
                tail--;
            else if (done)
                tail = TAIL_BITS;
            @(negedge CMD_CLK);
        end
        assert (dones == 1) else report_mismatch("done pulses", 1, dones);
        assert (rises == ((reps != 1) ? reps : 0))
            else report_mismatch("loop_start rises", (reps != 1) ? reps : 0, rises);
        // Data follows alternating sync bits on the line
        found_at = -1;
        for (i = 0; i <= MAX_OFFSET && found_at < 0; i++) begin
            if (i + exp_bits.size() + 8 <= cap_bits.size()) begin
                match = 1'b1;
                for (k = 1; k < i; k++)
                    if (cap_bits[k] == cap_bits[k-1])
                        match = 1'b0;
                for (k = 0; k < exp_bits.size(); k++)
                    if (cap_bits[i+k] != exp_bits[k])
                        match = 1'b0;
                if (match)
                    found_at = i;
            end
        end
        assert (found_at >= 0)
            else stop_with_failure("Command bytes were not found in the serial stream");
        for (k = found_at + exp_bits.size() + 1; k < found_at + exp_bits.size() + 8; k++)
            assert (cap_bits[k] != cap_bits[k-1])
                else stop_with_failure("Line did not return to sync bits after done");
    endtask

    task automatic check_ignored_start(input test_entry_t t);
        load_block(t);
        drive_start();
        check_idle_line(200);
    endtask

    initial begin : watchdog
        #(watchdog_cycles() * CLK_PERIOD);
        stop_with_failure("Watchdog timeout, the tests did not finish in time");
    end

    initial begin : main
        int t;
        lfsr     = LFSR_SEED;
        start    = 1'b0;
        mem_wr   = '0;
        cfg      = '0;
        @(negedge CMD_CLK);
        while (RST_SYNC)
            @(negedge CMD_CLK);
        check_lock_pattern(20);
        drive_start();                       // Leaves the lock pattern
        t = 0;
        do begin
            @(negedge CMD_CLK);
            t++;
        end while (!cmd_en && t < 10);
        assert (cmd_en) else stop_with_failure("cmd_en did not rise after the first start");
        check_idle_line(64);
        for (t = 0; t < NUM_TESTS; t++) begin
            if (TESTS[t].cmd_size == 16'd0)
                check_ignored_start(TESTS[t]);
            else
                run_playback(TESTS[t]);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// ==== compile.f ====
logic/cmd_line_pkg.sv
logic/cmd_cfg_pkg.sv
logic/cmd_sequencer_fsm.sv
logic/cmd_loop_counter.sv
logic/cmd_memory.sv
logic/cmd_serializer.sv
logic/cmd_encoder_top.sv
verification/tb_clock_gen.sv
verification/cmd_encoder_tb.sv
